// File: all.f
+incdir+verif
logic/usb_pkg.sv
logic/crc_shifter.sv
logic/bit_stuffer.sv
logic/nrzi_line_driver.sv
logic/packet_serializer.sv
logic/usb_tx.sv
verif/usb_tx_sva.sv
verif/usb_tx_tb.sv

// File: logic/bit_stuffer.sv
`timescale 1ns/1ns

module bit_stuffer (
  input  logic              clk,
  input  logic              rst_L,
  input  usb_pkg::usb_bit_t bit_in,
  output usb_pkg::usb_bit_t bit_out,
  output logic              stall
);

  localparam int CW = $clog2(usb_pkg::STUFF_RUN + 1);

  logic [CW-1:0] ones_cnt;
  logic [CW-1:0] run_base;
  logic          run_full;
  logic          last_q;

  // the run restarts with the first SYNC bit
  assign run_base = bit_in.first ? '0 : ones_cnt;

  // this bit completes a run, so a zero must follow it
  assign run_full = bit_in.valid && bit_in.value &&
                    (run_base == CW'(usb_pkg::STUFF_RUN - 1));

  assign stall = (ones_cnt == CW'(usb_pkg::STUFF_RUN));

  always_comb begin
    bit_out = bit_in;
    if (stall) begin
      bit_out.valid = 1'b1;
      bit_out.value = 1'b0;
      bit_out.first = 1'b0;
      bit_out.last  = last_q;
    end else begin
      // last flag moves onto the stuffed zero
      bit_out.last = bit_in.last & ~run_full;
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      ones_cnt <= '0;
      last_q   <= 1'b0;
    end else if (stall) begin
      ones_cnt <= '0;
      last_q   <= 1'b0;
    end else if (bit_in.valid) begin
      ones_cnt <= bit_in.value ? run_base + 1'b1 : '0;
      last_q   <= bit_in.last & run_full;
    end else begin
      ones_cnt <= '0;
      last_q   <= 1'b0;
    end
  end

endmodule

// File: logic/crc_shifter.sv
`timescale 1ns/1ns

module crc_shifter #(
  parameter int               WIDTH = 5,
  parameter logic [WIDTH-1:0] POLY  = '1
) (
  input  logic clk,
  input  logic rst_L,
  input  logic clear,
  input  logic advance,
  input  logic drain,
  input  logic bit_in,
  output logic crc_bit
);

  logic [WIDTH-1:0] rem;
  logic             fb;

  // feedback of the serial divider
  assign fb = rem[WIDTH-1] ^ bit_in;

  // remainder goes out inverted, MSB first
  assign crc_bit = drain ? ~rem[WIDTH-1] : 1'b0;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      rem <= '1;
    end else if (clear) begin
      rem <= '1;
    end else if (advance) begin
      if (drain)
        rem <= {rem[WIDTH-2:0], 1'b0};
      else if (fb)
        rem <= {rem[WIDTH-2:0], 1'b0} ^ POLY;
      else
        rem <= {rem[WIDTH-2:0], 1'b0};
    end
  end

endmodule

// File: logic/nrzi_line_driver.sv
`timescale 1ns/1ns

module nrzi_line_driver (
  input  logic               clk,
  input  logic               rst_L,
  input  usb_pkg::usb_bit_t  bit_in,
  output usb_pkg::usb_line_t line,
  output logic               pkt_sent
);

  typedef enum logic [2:0] {IDLE, PACKET, EOP1, EOP2, EOP3} drv_state_t;

  localparam usb_pkg::usb_line_t LINE_IDLE = '{dp: 1'b1, dm: 1'b0, oe: 1'b0};
  localparam usb_pkg::usb_line_t LINE_SE0  = '{dp: 1'b0, dm: 1'b0, oe: 1'b1};
  localparam usb_pkg::usb_line_t LINE_J    = '{dp: 1'b1, dm: 1'b0, oe: 1'b1};

  // state names the symbol currently on the line
  drv_state_t         state;
  drv_state_t         state_nxt;
  usb_pkg::usb_line_t line_nxt;
  logic               level;
  logic               level_nxt;
  logic               last_q;
  logic               last_nxt;
  logic               base;
  logic               coded;

  // every packet starts from J, a zero toggles and a one holds
  assign base  = bit_in.first ? 1'b1 : level;
  assign coded = bit_in.value ? base : ~base;

  assign pkt_sent = (state == EOP3);

  always_comb begin
    state_nxt = state;
    line_nxt  = LINE_IDLE;
    level_nxt = level;
    last_nxt  = 1'b0;
    case (state)
      EOP1: begin
        state_nxt = EOP2;
        line_nxt  = LINE_SE0;
      end
      EOP2: begin
        state_nxt = EOP3;
        line_nxt  = LINE_J;
      end
      EOP3: begin
        state_nxt = IDLE;
      end
      default: begin
        if (state == PACKET && last_q) begin
          state_nxt = EOP1;
          line_nxt  = LINE_SE0;
        end else if (bit_in.valid) begin
          state_nxt = PACKET;
          line_nxt  = '{dp: coded, dm: ~coded, oe: 1'b1};
          level_nxt = coded;
          last_nxt  = bit_in.last;
        end else begin
          state_nxt = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state  <= IDLE;
      line   <= LINE_IDLE;
      level  <= 1'b1;
      last_q <= 1'b0;
    end else begin
      state  <= state_nxt;
      line   <= line_nxt;
      level  <= level_nxt;
      last_q <= last_nxt;
    end
  end

endmodule

// File: logic/packet_serializer.sv
`timescale 1ns/1ns

module packet_serializer (
  input  logic               clk,
  input  logic               rst_L,
  input  logic               pkt_valid,
  input  usb_pkg::usb_pkt_t  pkt,
  input  logic               stall,
  input  logic               crc5_bit,
  input  logic               crc16_bit,
  input  logic               pkt_sent,
  output usb_pkg::usb_bit_t  raw_bit,
  output logic               busy,
  output logic [2:0]         crc5_ctl,
  output logic [2:0]         crc16_ctl
);

  usb_pkg::usb_pkt_t   req;
  usb_pkg::ser_state_t state;
  usb_pkg::ser_state_t next_field;
  logic                start_q;
  logic [5:0]          bit_cnt;
  logic [5:0]          field_max;
  logic                field_end;
  logic                accept;
  logic                step;
  logic                is_token;
  logic                is_data;
  logic                pkt_end;
  logic                value;

  // only one request at a time, no queue
  assign accept = pkt_valid & ~busy;
  assign step   = (state != usb_pkg::IDLE) & ~stall;

  assign is_token = (req.pid == usb_pkg::PID_OUT) || (req.pid == usb_pkg::PID_IN);
  assign is_data  = (req.pid == usb_pkg::PID_DATA0);

  // index of the final bit of the current field
  always_comb begin
    case (state)
      usb_pkg::SYNC:  field_max = 6'(usb_pkg::SYNC_LEN - 1);
      usb_pkg::PID:   field_max = 6'($bits(usb_pkg::pid_t) - 1);
      usb_pkg::ADDR:  field_max = 6'($bits(usb_pkg::addr_t) - 1);
      usb_pkg::ENDP:  field_max = 6'($bits(usb_pkg::endp_t) - 1);
      usb_pkg::CRC5:  field_max = 6'd4;
      usb_pkg::DATA:  field_max = 6'($bits(usb_pkg::data_t) - 1);
      usb_pkg::CRC16: field_max = 6'd15;
      default:        field_max = 6'd0;
    endcase
  end

  assign field_end = (bit_cnt == field_max);

  always_comb begin
    case (state)
      usb_pkg::SYNC:  next_field = usb_pkg::PID;
      usb_pkg::PID: begin
        if (is_token)
          next_field = usb_pkg::ADDR;
        else if (is_data)
          next_field = usb_pkg::DATA;
        else
          next_field = usb_pkg::IDLE;
      end
      usb_pkg::ADDR:  next_field = usb_pkg::ENDP;
      usb_pkg::ENDP:  next_field = usb_pkg::CRC5;
      usb_pkg::DATA:  next_field = usb_pkg::CRC16;
      default:        next_field = usb_pkg::IDLE;
    endcase
  end

  // bit mux, fields go out LSB first and CRCs come from the shifters
  always_comb begin
    case (state)
      usb_pkg::SYNC:  value = field_end;
      usb_pkg::PID:   value = req.pid[bit_cnt[2:0]];
      usb_pkg::ADDR:  value = req.addr[bit_cnt[2:0]];
      usb_pkg::ENDP:  value = req.endp[bit_cnt[1:0]];
      usb_pkg::CRC5:  value = crc5_bit;
      usb_pkg::DATA:  value = req.data[bit_cnt];
      usb_pkg::CRC16: value = crc16_bit;
      default:        value = 1'b0;
    endcase
  end

  // handshake-style packets end right after the PID
  assign pkt_end = field_end &&
                   ((state == usb_pkg::CRC5) || (state == usb_pkg::CRC16) ||
                    (state == usb_pkg::PID && !is_token && !is_data));

  assign raw_bit.valid = (state != usb_pkg::IDLE);
  assign raw_bit.value = value;
  assign raw_bit.first = (state == usb_pkg::SYNC) && (bit_cnt == 6'd0);
  assign raw_bit.last  = pkt_end;

  // shifters absorb the bit on the line and drain during their CRC field
  assign crc5_ctl = {accept,
                     step & (state inside {usb_pkg::ADDR, usb_pkg::ENDP, usb_pkg::CRC5}),
                     state == usb_pkg::CRC5};
  assign crc16_ctl = {accept,
                      step & (state inside {usb_pkg::DATA, usb_pkg::CRC16}),
                      state == usb_pkg::CRC16};

  always_ff @(posedge clk) begin
    if (accept)
      req <= pkt;
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state   <= usb_pkg::IDLE;
      bit_cnt <= '0;
      start_q <= 1'b0;
      busy    <= 1'b0;
    end else begin
      if (accept)
        busy <= 1'b1;
      else if (pkt_sent)
        busy <= 1'b0;

      if (accept) begin
        start_q <= 1'b1;
      end else if (state == usb_pkg::IDLE && start_q) begin
        // one cycle after the request, SYNC starts
        start_q <= 1'b0;
        state   <= usb_pkg::SYNC;
        bit_cnt <= '0;
      end else if (step) begin
        if (field_end) begin
          bit_cnt <= '0;
          state   <= next_field;
        end else begin
          bit_cnt <= bit_cnt + 6'd1;
        end
      end
    end
  end

endmodule

// File: logic/usb_pkg.sv
package usb_pkg;

  // widths that carry a meaning on the bus
  typedef logic [7:0]  pid_t;
  typedef logic [6:0]  addr_t;
  typedef logic [3:0]  endp_t;
  typedef logic [63:0] data_t;

  // PID bytes, sent LSB first
  localparam pid_t PID_OUT   = 8'b1110_0001;
  localparam pid_t PID_IN    = 8'b0110_1001;
  localparam pid_t PID_DATA0 = 8'b1100_0011;
  localparam pid_t PID_ACK   = 8'b1101_0010;
  localparam pid_t PID_NAK   = 8'b0101_1010;

  // x^5 + x^2 + 1 and x^16 + x^15 + x^2 + 1, top term implied
  localparam logic [4:0]  CRC5_POLY  = 5'b00101;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  localparam int SYNC_LEN  = 8;
  localparam int STUFF_RUN = 6;

  // one packet request, 83 bits
  typedef struct packed {
    pid_t  pid;
    addr_t addr;
    endp_t endp;
    data_t data;
  } usb_pkt_t;

  // one stream bit with its framing flags
  typedef struct packed {
    logic valid;
    logic value;
    logic first;
    logic last;
  } usb_bit_t;

  // one line symbol
  typedef struct packed {
    logic dp;
    logic dm;
    logic oe;
  } usb_line_t;

  typedef enum logic [2:0] {
    IDLE, SYNC, PID, ADDR, ENDP, CRC5, DATA, CRC16
  } ser_state_t;

endpackage

// File: logic/usb_tx.sv
`timescale 1ns/1ns

module usb_tx (
  input  logic                clk,
  input  logic                rst_L,
  input  logic                pkt_valid,
  input  usb_pkg::usb_pkt_t   pkt,
  output usb_pkg::usb_line_t  line,
  output logic                busy,
  output logic                pkt_sent
);

  usb_pkg::usb_bit_t raw_bit;
  usb_pkg::usb_bit_t stuffed_bit;
  logic              stall;
  logic              crc5_bit;
  logic              crc16_bit;
  // control bits are {clear, advance, drain}
  logic [2:0]        crc5_ctl;
  logic [2:0]        crc16_ctl;

  packet_serializer u_ser (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .stall     (stall),
    .crc5_bit  (crc5_bit),
    .crc16_bit (crc16_bit),
    .pkt_sent  (pkt_sent),
    .raw_bit   (raw_bit),
    .busy      (busy),
    .crc5_ctl  (crc5_ctl),
    .crc16_ctl (crc16_ctl)
  );

  // token CRC over address and endpoint
  crc_shifter #(.WIDTH(5), .POLY(usb_pkg::CRC5_POLY)) u_crc5 (
    .clk     (clk),
    .rst_L   (rst_L),
    .clear   (crc5_ctl[2]),
    .advance (crc5_ctl[1]),
    .drain   (crc5_ctl[0]),
    .bit_in  (raw_bit.value),
    .crc_bit (crc5_bit)
  );

  // data CRC over the 64-bit payload
  crc_shifter #(.WIDTH(16), .POLY(usb_pkg::CRC16_POLY)) u_crc16 (
    .clk     (clk),
    .rst_L   (rst_L),
    .clear   (crc16_ctl[2]),
    .advance (crc16_ctl[1]),
    .drain   (crc16_ctl[0]),
    .bit_in  (raw_bit.value),
    .crc_bit (crc16_bit)
  );

  bit_stuffer u_stuff (
    .clk     (clk),
    .rst_L   (rst_L),
    .bit_in  (raw_bit),
    .bit_out (stuffed_bit),
    .stall   (stall)
  );

  nrzi_line_driver u_drv (
    .clk      (clk),
    .rst_L    (rst_L),
    .bit_in   (stuffed_bit),
    .line     (line),
    .pkt_sent (pkt_sent)
  );

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module usb_tx_tb -f all.f -o usb_tx_sim &&
./obj_dir/usb_tx_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: verif/usb_tx_sva.sv
`timescale 1ns/1ns

module usb_tx_sva (
  input logic               clk,
  input logic               rst_L,
  input usb_pkg::usb_line_t line,
  input logic               busy,
  input logic               pkt_sent
);

  // SE0 is legal while driving, SE1 never is
  property no_se1;
    @(posedge clk) disable iff (!rst_L)
      line.oe |-> !(line.dp && line.dm);
  endproperty

  property sent_is_pulse;
    @(posedge clk) disable iff (!rst_L)
      pkt_sent |=> !pkt_sent;
  endproperty

  // the line is only driven inside a request
  property busy_while_driving;
    @(posedge clk) disable iff (!rst_L)
      line.oe |-> busy;
  endproperty

  assert property (no_se1) else $error("dp and dm both high while oe is set");
  assert property (sent_is_pulse) else $error("pkt_sent held for more than one cycle");
  assert property (busy_while_driving) else $error("line driven while busy is low");

endmodule

bind usb_tx usb_tx_sva u_sva (
  .clk      (clk),
  .rst_L    (rst_L),
  .line     (line),
  .busy     (busy),
  .pkt_sent (pkt_sent)
);

// File: verif/usb_tx_model.svh
`ifndef USB_TX_MODEL_SVH
`define USB_TX_MODEL_SVH

// expected line symbols of one request, rebuilt per packet
bit                 raw_q[$];
bit                 stuffed_q[$];
usb_pkg::usb_line_t exp_line_q[$];

// fields go out LSB first
task automatic push_field(input logic [63:0] val, input int len);
  int i;
  for (i = 0; i < len; i++)
    raw_q.push_back(val[i]);
endtask

// bitwise division from an all-ones preset, remainder inverted and sent MSB first
task automatic push_crc(input int width, input logic [15:0] poly, input int from);
  logic [15:0] rem;
  logic        fb;
  int          i;
  int          stop;
  rem  = '1;
  stop = raw_q.size();
  for (i = from; i < stop; i++) begin
    fb  = rem[width-1] ^ raw_q[i];
    rem = {rem[14:0], 1'b0};
    if (fb)
      rem = rem ^ poly;
  end
  for (i = width - 1; i >= 0; i--)
    raw_q.push_back(~rem[i]);
endtask

task automatic push_symbol(input logic dp, input logic dm);
  usb_pkg::usb_line_t sym;
  sym.dp = dp;
  sym.dm = dm;
  sym.oe = 1'b1;
  exp_line_q.push_back(sym);
endtask

task automatic build_expected(input usb_pkg::usb_pkt_t req);
  int   i;
  int   ones;
  int   from;
  logic level;
  raw_q.delete();
  stuffed_q.delete();
  exp_line_q.delete();
  // SYNC is seven zeros and then a one
  push_field(64'h80, usb_pkg::SYNC_LEN);
  push_field(64'(req.pid), 8);
  if (req.pid == usb_pkg::PID_OUT || req.pid == usb_pkg::PID_IN) begin
    from = raw_q.size();
    push_field(64'(req.addr), 7);
    push_field(64'(req.endp), 4);
    push_crc(5, 16'(usb_pkg::CRC5_POLY), from);
  end else if (req.pid == usb_pkg::PID_DATA0) begin
    from = raw_q.size();
    push_field(req.data, 64);
    push_crc(16, usb_pkg::CRC16_POLY, from);
  end
  // zero after every run of six ones, the final bit included
  ones = 0;
  for (i = 0; i < raw_q.size(); i++) begin
    stuffed_q.push_back(raw_q[i]);
    ones = raw_q[i] ? ones + 1 : 0;
    if (ones == usb_pkg::STUFF_RUN) begin
      stuffed_q.push_back(1'b0);
      ones = 0;
    end
  end
  // NRZI from J
  level = 1'b1;
  for (i = 0; i < stuffed_q.size(); i++) begin
    if (!stuffed_q[i])
      level = ~level;
    push_symbol(level, ~level);
  end
  // EOP is SE0, SE0, J
  push_symbol(1'b0, 1'b0);
  push_symbol(1'b0, 1'b0);
  push_symbol(1'b1, 1'b0);
endtask

`endif

// File: verif/usb_tx_tb.sv
`timescale 1ns/1ns

module usb_tx_tb;

  localparam int OE_LATENCY = 2;
  localparam int OE_TIMEOUT = 20;
  localparam usb_pkg::usb_line_t IDLE_LINE = '{dp: 1'b1, dm: 1'b0, oe: 1'b0};

  logic               clk;
  logic               rst_L;
  logic               pkt_valid;
  usb_pkg::usb_pkt_t  pkt;
  usb_pkg::usb_line_t line;
  logic               busy;
  logic               pkt_sent;

  usb_tx uut (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .line      (line),
    .busy      (busy),
    .pkt_sent  (pkt_sent)
  );

  `include "usb_tx_model.svh"

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_line(input string name, input usb_pkg::usb_line_t exp,
                            input usb_pkg::usb_line_t act);
    if (act !== exp)
      abort_run($sformatf("mismatch %s: dp,dm,oe expected %b actual %b", name, exp, act));
  endtask

  task automatic check_sent(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("mismatch %s: pkt_sent expected %b actual %b", name, exp, act));
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("mismatch %s: busy expected %b actual %b", name, exp, act));
  endtask

  // inputs change and outputs are read 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic usb_pkg::usb_pkt_t random_pkt(input usb_pkg::pid_t pid);
    usb_pkg::usb_pkt_t p;
    p.pid  = pid;
    p.addr = 7'($urandom);
    p.endp = 4'($urandom);
    p.data = {$urandom, $urandom};
    return p;
  endfunction

  function automatic usb_pkg::pid_t other_pid();
    usb_pkg::pid_t pid;
    pid = 8'($urandom);
    if (pid == usb_pkg::PID_OUT || pid == usb_pkg::PID_IN || pid == usb_pkg::PID_DATA0)
      pid = usb_pkg::PID_NAK;
    return pid;
  endfunction

  // stray requests while busy must all be dropped
  task automatic poke_request();
    pkt_valid = 1'($urandom);
    pkt       = random_pkt(8'($urandom));
  endtask

  task automatic check_quiet(input string name, input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      check_line(name, IDLE_LINE, line);
      check_busy(name, 1'b0, busy);
      check_sent(name, 1'b0, pkt_sent);
      next_cycle();
    end
  endtask

  task automatic run_packet(input string name, input usb_pkg::usb_pkt_t req, input bit poke);
    int    cyc;
    int    idx;
    string tag;
    build_expected(req);
    pkt       = req;
    pkt_valid = 1'b1;
    next_cycle();
    pkt_valid = 1'b0;
    check_busy(name, 1'b1, busy);
    cyc = 0;
    while (!line.oe) begin
      if (cyc == OE_TIMEOUT) begin
        abort_run($sformatf("%s: the line was never enabled after the request", name));
      end else begin
        if (poke)
          poke_request();
        next_cycle();
        cyc++;
      end
    end
    if (cyc != OE_LATENCY)
      abort_run($sformatf("mismatch %s: oe latency expected %0d actual %0d",
                          name, OE_LATENCY, cyc));
    // the expected length bounds the capture
    idx = 0;
    while (line.oe) begin
      if (idx >= exp_line_q.size()) begin
        abort_run($sformatf("%s: the line stayed enabled past the end of the packet", name));
      end else begin
        tag = $sformatf("%s symbol %0d", name, idx);
        check_line(tag, exp_line_q[idx], line);
        check_sent(tag, idx == exp_line_q.size() - 1, pkt_sent);
        check_busy(tag, 1'b1, busy);
        if (poke)
          poke_request();
        next_cycle();
        idx++;
      end
    end
    pkt_valid = 1'b0;
    if (idx != exp_line_q.size())
      abort_run($sformatf("mismatch %s: symbol count expected %0d actual %0d",
                          name, exp_line_q.size(), idx));
    check_quiet({name, " gap"}, 3);
  endtask

  initial begin
    usb_pkg::usb_pkt_t req;
    int                n;
    void'($urandom(26));
    clk       = 1'b0;
    rst_L     = 1'b0;
    pkt_valid = 1'b0;
    pkt       = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_L = 1'b1;
    check_quiet("after_reset", 4);

    for (n = 0; n < 16; n++) begin
      req = random_pkt((($urandom & 1) != 0) ? usb_pkg::PID_OUT : usb_pkg::PID_IN);
      run_packet("token", req, 1'b0);
    end
    for (n = 0; n < 16; n++)
      run_packet("data0", random_pkt(usb_pkg::PID_DATA0), 1'b0);

    run_packet("ack", random_pkt(usb_pkg::PID_ACK), 1'b0);
    run_packet("nak", random_pkt(usb_pkg::PID_NAK), 1'b0);
    for (n = 0; n < 8; n++)
      run_packet("other_pid", random_pkt(other_pid()), 1'b0);

    // long runs of ones
    req      = random_pkt(usb_pkg::PID_DATA0);
    req.data = '1;
    run_packet("runs_data", req, 1'b0);
    req      = random_pkt(usb_pkg::PID_OUT);
    req.addr = 7'h7f;
    req.endp = 4'hf;
    run_packet("runs_out", req, 1'b0);
    req      = random_pkt(usb_pkg::PID_IN);
    req.addr = 7'h7e;
    run_packet("runs_in", req, 1'b0);
    run_packet("runs_pid_ff", random_pkt(8'hff), 1'b0);
    // the last six PID bits are ones, so the stuffed zero trails the final bit
    run_packet("runs_final", random_pkt(8'hfc), 1'b0);

    for (n = 0; n < 8; n++) begin
      case (n % 3)
        0:       req = random_pkt(usb_pkg::PID_OUT);
        1:       req = random_pkt(usb_pkg::PID_DATA0);
        default: req = random_pkt(other_pid());
      endcase
      run_packet("busy_ignore", req, 1'b1);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule
